/* axis2axi/axis2axi_out.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_cfg.svh"

module axis2axi_out (
   input  wire                      clk_i,
   input  wire                      reset_i,

   // Transfer request
   input  wire  [`AXI_ADDR_W-1:0]   config_addr_i,
   input  wire  [`AXI_ADDR_W-1:0]   config_length_i,
   input  wire                      config_valid_i,
   output logic                     config_ready_o,

   // AR channel
   output logic [`AXI_ADDR_W-1:0]   axi_araddr_o,
   output logic [`AXI_LEN_W-1:0]    axi_arlen_o,
   output axi_pkg::axi_size_t       axi_arsize_o,
   output axi_pkg::axi_burst_t      axi_arburst_o,
   output logic                     axi_arvalid_o,
   input  wire                      axi_arready_i,

   // R channel
   input  wire  [`AXI_DATA_W-1:0]   axi_rdata_i,
   input  wire                      axi_rlast_i,
   input  wire                      axi_rvalid_i,
   output logic                     axi_rready_o,

   // Stream out
   output logic [`AXI_DATA_W-1:0]   stream_data_o,
   output logic                     stream_valid_o,
   input  wire                      stream_ready_i
);

   import axi_pkg::*;
   import dma_pkg::*;

   localparam int ADDR_W = `AXI_ADDR_W;
   localparam int LEN_W  = `AXI_LEN_W;

   rd_state_t              state_q;
   logic [`AXI_ADDR_W-1:0] addr_q;
   logic [`AXI_ADDR_W-1:0] remain_q;
   logic [`AXI_LEN_W-1:0]  arlen_q;
   logic [`BURST_W:0]      burst_size;
   logic [`AXI_ADDR_W-1:0] burst_bytes;
   logic                   last_beat;

   burst_len_calc u_burst_len_calc (
      .address_i    (addr_q),
      .remaining_i  (remain_q),
      .burst_size_o (burst_size)
   );

   // Final beat of the current burst leaves the R channel
   assign last_beat = (state_q == END_LOCAL) && axi_rvalid_i && stream_ready_i && axi_rlast_i;

   // Bytes covered by the burst in flight
   assign burst_bytes = (ADDR_W'(arlen_q) + 1'b1) << 2;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= WAIT_START;
      end else begin
         case (state_q)
            WAIT_START: begin
               // Zero length is taken and dropped here
               if (config_valid_i && (config_length_i != '0)) begin
                  state_q <= BEGIN_LOCAL;
               end
            end
            BEGIN_LOCAL: begin
               state_q <= TRANSFER;
            end
            TRANSFER: begin
               if (axi_arready_i) begin
                  state_q <= END_LOCAL;
               end
            end
            END_LOCAL: begin
               if (last_beat) begin
                  state_q <= (remain_q == '0) ? WAIT_START : BEGIN_LOCAL;
               end
            end
            default: begin
               state_q <= WAIT_START;
            end
         endcase
      end
   end

   // Address, word count and burst length
   always_ff @(posedge clk_i) begin
      if ((state_q == WAIT_START) && config_valid_i) begin
         addr_q   <= config_addr_i;
         remain_q <= config_length_i;
      end
      if (state_q == BEGIN_LOCAL) begin
         remain_q <= remain_q - ADDR_W'(burst_size);
         arlen_q  <= LEN_W'(burst_size - 1'b1);
      end
      if (last_beat) begin
         addr_q <= addr_q + burst_bytes;
      end
   end

   assign config_ready_o = (state_q == WAIT_START);

   assign axi_araddr_o  = addr_q;
   assign axi_arlen_o   = arlen_q;
   assign axi_arsize_o  = SIZE_4B;
   assign axi_arburst_o = BURST_INCR;
   assign axi_arvalid_o = (state_q == TRANSFER);

   // Zero latency path, stream back-pressure stalls R directly
   assign axi_rready_o   = (state_q == END_LOCAL) && stream_ready_i;
   assign stream_valid_o = (state_q == END_LOCAL) && axi_rvalid_i;
   assign stream_data_o  = axi_rdata_i;

endmodule

`default_nettype wire

/* axis2axi/burst_len_calc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_cfg.svh"

module burst_len_calc (
   input  wire  [`AXI_ADDR_W-1:0] address_i,
   input  wire  [`AXI_ADDR_W-1:0] remaining_i,
   output logic [`BURST_W:0]      burst_size_o
);

   localparam int ADDR_W    = `AXI_ADDR_W;
   localparam int SIZE_W    = `BURST_W + 1;
   localparam int MAX_BURST = 2 ** `BURST_W;

   logic [`BURST_W:0] capped_size;

   // Remaining words, capped at the longest burst
   always_comb begin
      if (remaining_i >= ADDR_W'(MAX_BURST)) begin
         capped_size = SIZE_W'(MAX_BURST);
      end else begin
         capped_size = remaining_i[`BURST_W:0];
      end
   end

   generate
      if (ADDR_W >= 13) begin : g_boundary
         logic [12:0] words_to_line;

         // Words left before the next 4 KB line
         assign words_to_line = (13'h1000 - {1'b0, address_i[11:0]}) >> 2;

         always_comb begin
            if (capped_size > words_to_line) begin
               burst_size_o = words_to_line[`BURST_W:0];
            end else begin
               burst_size_o = capped_size;
            end
         end
      end else begin : g_no_boundary
         assign burst_size_o = capped_size;
      end
   endgenerate

endmodule

`default_nettype wire

/* bench/axis2axi_out_assert.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_cfg.svh"

module axis2axi_out_assert (
   input  wire                      clk_i,
   input  wire                      reset_i,
   input  var   dma_pkg::rd_state_t state_i,
   input  wire  [`AXI_ADDR_W-1:0]   axi_araddr_i,
   input  wire  [`AXI_LEN_W-1:0]    axi_arlen_i,
   input  wire                      axi_arvalid_i,
   input  wire                      axi_arready_i,
   input  wire  [`AXI_DATA_W-1:0]   stream_data_i,
   input  wire                      stream_valid_i,
   input  wire                      stream_ready_i
);

   import dma_pkg::*;

   localparam logic [`AXI_LEN_W-1:0] MAX_ARLEN = `AXI_LEN_W'((2 ** `BURST_W) - 1);

   logic [12:0] burst_end;

   // Byte just past the burst within its 4 KB page
   assign burst_end = {1'b0, axi_araddr_i[11:0]} + {3'b000, axi_arlen_i, 2'b00} + 13'd4;

   arlen_max: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_arvalid_i |-> (axi_arlen_i <= MAX_ARLEN))
      else $error("arlen %0d above the longest burst", axi_arlen_i);

   no_4kb_cross: assert property (@(posedge clk_i) disable iff (reset_i)
      axi_arvalid_i |-> (burst_end <= 13'h1000))
      else $error("burst at %h with arlen %0d crosses 4 KB", axi_araddr_i, axi_arlen_i);

   ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      (axi_arvalid_i && !axi_arready_i) |=>
         (axi_arvalid_i && $stable(axi_araddr_i) && $stable(axi_arlen_i)))
      else $error("AR request changed before arready");

   stream_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      (stream_valid_i && !stream_ready_i) |=> (stream_valid_i && $stable(stream_data_i)))
      else $error("stream beat dropped or changed under back-pressure");

   // Memory stays busy while the engine still reads a burst
   burst_open: assert property (@(posedge clk_i) disable iff (reset_i)
      (state_i == END_LOCAL) |-> !axi_arready_i)
      else $error("memory ready for a new burst while the engine still reads one");

endmodule

bind axis2axi_out axis2axi_out_assert u_axis2axi_out_assert (
   .clk_i          (clk_i),
   .reset_i        (reset_i),
   .state_i        (state_q),
   .axi_araddr_i   (axi_araddr_o),
   .axi_arlen_i    (axi_arlen_o),
   .axi_arvalid_i  (axi_arvalid_o),
   .axi_arready_i  (axi_arready_i),
   .stream_data_i  (stream_data_o),
   .stream_valid_i (stream_valid_o),
   .stream_ready_i (stream_ready_i)
);

`default_nettype wire

/* bench/tb_axis2axi_rd.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_cfg.svh"

module tb_axis2axi_rd;

   localparam int CLK_PERIOD = 4;
   localparam int MEM_WORDS = 2 ** `MEM_ADDR_W;
   localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1;
   localparam logic [31:0] SEED = 32'h4b73_2c1a;
   // 40 + 20 + 0 + 37 words over all requests
   localparam int TOTAL_WORDS = 97;
   localparam int TIME_LIMIT = (TOTAL_WORDS * 64 + MEM_WORDS + 300) * CLK_PERIOD;

   logic                    clk_i;
   logic                    reset_i;
   logic [`AXI_ADDR_W-1:0]  config_addr_i;
   logic [`AXI_ADDR_W-1:0]  config_length_i;
   logic                    config_valid_i;
   logic                    config_ready_o;
   logic [`AXI_DATA_W-1:0]  stream_data_o;
   logic                    stream_valid_o;
   logic                    stream_ready_i = 1'b1;
   logic                    load_en_i;
   logic [`MEM_ADDR_W-1:0]  load_addr_i;
   logic [`AXI_DATA_W-1:0]  load_data_i;

   logic [31:0]             rng_state = SEED;
   logic                    random_ready = 1'b0;
   logic [31:0]             expected_q [$];
   logic [31:0]             want;

   axis2axi_rd_sys dut0 (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .config_addr_i   (config_addr_i),
      .config_length_i (config_length_i),
      .config_valid_i  (config_valid_i),
      .config_ready_o  (config_ready_o),
      .stream_data_o   (stream_data_o),
      .stream_valid_o  (stream_valid_o),
      .stream_ready_i  (stream_ready_i),
      .load_en_i       (load_en_i),
      .load_addr_i     (load_addr_i),
      .load_data_i     (load_data_i)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Preloaded word at a byte address with the 8 KB wrap of the memory
   function automatic logic [31:0] word_at(input logic [`AXI_ADDR_W-1:0] byte_addr);
      logic [`MEM_ADDR_W-1:0] index;
      index = byte_addr[`MEM_ADDR_W+1:2];
      return 32'(index) ^ FILL_KEY;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
   endtask

   task automatic abort_run(input string what);
      $display("Error at %0t: %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "check failed");
   endtask

   task automatic preload_memory;
      for (int i = 0; i < MEM_WORDS; i++) begin
         @(negedge clk_i);
         load_en_i = 1'b1;
         load_addr_i = `MEM_ADDR_W'(i);
         load_data_i = 32'(i) ^ FILL_KEY;
      end
      @(negedge clk_i);
      load_en_i = 1'b0;
   endtask

   // Issue one request and wait for the engine to go idle again
   task automatic request_words(input logic [`AXI_ADDR_W-1:0] addr, input int unsigned words);
      logic [`AXI_ADDR_W-1:0] a;
      @(negedge clk_i);
      assert (config_ready_o) else abort_run("config_ready_o low before a new request");
      config_addr_i = addr;
      config_length_i = `AXI_ADDR_W'(words);
      config_valid_i = 1'b1;
      @(negedge clk_i);
      config_valid_i = 1'b0;
      a = addr;
      for (int unsigned n = 0; n < words; n++) begin
         expected_q.push_back(word_at(a));
         a = a + `AXI_ADDR_W'(4);
      end
      if (words == 0) begin
         repeat (20) begin
            assert (config_ready_o)
               else abort_run("config_ready_o dropped for a zero-length request");
            @(negedge clk_i);
         end
      end else begin
         assert (!config_ready_o)
            else abort_run("config_ready_o still high after a request was accepted");
         while (!config_ready_o) begin
            @(negedge clk_i);
         end
         assert (expected_q.size() == 0)
            else abort_run("transfer ended with words still missing");
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         clk_i = ~clk_i;
      end
   end

   // Ready is high about three cycles in four when random
   always @(negedge clk_i) begin
      if (random_ready) begin
         rng_state = xorshift32(rng_state);
         stream_ready_i <= rng_state[0] | rng_state[3];
      end else begin
         stream_ready_i <= 1'b1;
      end
   end

   always @(posedge clk_i) begin
      if (!reset_i) begin
         if (stream_valid_o && stream_ready_i) begin
            assert (expected_q.size() != 0)
               else abort_run("stream beat delivered with no word outstanding");
            if (expected_q.size() != 0) begin
               want = expected_q.pop_front();
               assert (stream_data_o == want)
                  else report_mismatch("stream_data_o", want, stream_data_o);
            end
         end
         assert (expected_q.size() == 0 || !config_ready_o)
            else abort_run("config_ready_o high while words are still outstanding");
      end
   end

   initial begin
      #(TIME_LIMIT);
      $display("Watchdog expired at %0t: the run hung before all transfers finished", $time);
      $display("Simulation failed");
      $fatal(1, "timeout");
   end

   initial begin
      reset_i = 1'b1;
      config_addr_i = '0;
      config_length_i = '0;
      config_valid_i = 1'b0;
      load_en_i = 1'b0;
      load_addr_i = '0;
      load_data_i = '0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;
      assert (config_ready_o) else abort_run("config_ready_o low after reset");
      assert (!stream_valid_o) else abort_run("stream_valid_o high after reset");
      preload_memory();
      // Three bursts of 16, 16 and 8
      request_words(16'h0000, 40);
      random_ready = 1'b1;
      // Crosses the 4 KB line three words in
      request_words(16'h0ff4, 20);
      request_words(16'h0100, 0);
      request_words(16'h0104, 37);
      repeat (10) @(negedge clk_i);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* common/axi_pkg.sv */
`default_nettype none

package axi_pkg;

   // arburst encodings
   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_t;

   // arsize, bytes per beat as a power of two
   typedef enum logic [2:0] {
      SIZE_1B   = 3'd0,
      SIZE_2B   = 3'd1,
      SIZE_4B   = 3'd2,
      SIZE_8B   = 3'd3,
      SIZE_16B  = 3'd4,
      SIZE_32B  = 3'd5,
      SIZE_64B  = 3'd6,
      SIZE_128B = 3'd7
   } axi_size_t;

endpackage

`default_nettype wire

/* common/axis2axi_cfg.svh */
`ifndef AXIS2AXI_CFG_SVH
`define AXIS2AXI_CFG_SVH

// Byte address and word length width
// Kept at 13 or above so the 4 KB split stays in the design
`define AXI_ADDR_W 16

// Only 4-byte beats
`define AXI_DATA_W 32

// Width of arlen
`define AXI_LEN_W 8

// log2 of the longest burst, 16 beats
`define BURST_W 4

// Memory word address, 8 KB in total
`define MEM_ADDR_W 11

`endif

/* common/dma_pkg.sv */
`default_nettype none

package dma_pkg;

   // Read engine states
   typedef enum logic [1:0] {
      WAIT_START  = 2'd0,
      BEGIN_LOCAL = 2'd1,
      TRANSFER    = 2'd2,
      END_LOCAL   = 2'd3
   } rd_state_t;

endpackage

`default_nettype wire

/* hw/axi_rd_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_cfg.svh"

module axi_rd_mem (
   input  wire                      clk_i,
   input  wire                      reset_i,

   // Preload port, word addressed
   input  wire                      load_en_i,
   input  wire  [`MEM_ADDR_W-1:0]   load_addr_i,
   input  wire  [`AXI_DATA_W-1:0]   load_data_i,

   // AR channel
   input  wire  [`AXI_ADDR_W-1:0]   axi_araddr_i,
   input  wire  [`AXI_LEN_W-1:0]    axi_arlen_i,
   input  var   axi_pkg::axi_burst_t axi_arburst_i,
   input  wire                      axi_arvalid_i,
   output logic                     axi_arready_o,

   // R channel
   output logic [`AXI_DATA_W-1:0]   axi_rdata_o,
   output logic                     axi_rlast_o,
   output logic                     axi_rvalid_o,
   input  wire                      axi_rready_i
);

   import axi_pkg::*;

   typedef enum logic {
      MEM_IDLE,
      MEM_BURST
   } mem_state_t;

   localparam int WORDS = 2 ** `MEM_ADDR_W;

   logic [`AXI_DATA_W-1:0] mem [WORDS];

   mem_state_t             state_q;
   logic [`MEM_ADDR_W-1:0] word_addr_q;
   logic [`MEM_ADDR_W-1:0] ar_word_addr;
   logic [`MEM_ADDR_W-1:0] next_word_addr;
   logic [`AXI_LEN_W-1:0]  beats_left_q;
   logic                   incr_q;
   logic                   ar_fire;
   logic                   r_fire;

   // Byte address to word index, upper bits dropped
   assign ar_word_addr = axi_araddr_i[`MEM_ADDR_W+1:2];

   // Only INCR steps the address
   assign next_word_addr = incr_q ? word_addr_q + 1'b1 : word_addr_q;

   assign ar_fire = axi_arvalid_i && axi_arready_o;
   assign r_fire  = axi_rvalid_o && axi_rready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= MEM_IDLE;
      end else if ((state_q == MEM_IDLE) && ar_fire) begin
         state_q <= MEM_BURST;
      end else if ((state_q == MEM_BURST) && r_fire && axi_rlast_o) begin
         state_q <= MEM_IDLE;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_en_i) begin
         mem[load_addr_i] <= load_data_i;
      end
      if (ar_fire) begin
         word_addr_q  <= ar_word_addr;
         beats_left_q <= axi_arlen_i;
         incr_q       <= (axi_arburst_i == BURST_INCR);
         axi_rdata_o  <= mem[ar_word_addr];
      end else if (r_fire && !axi_rlast_o) begin
         // Prefetch the next beat, rdata holds while rready is low
         word_addr_q  <= next_word_addr;
         beats_left_q <= beats_left_q - 1'b1;
         axi_rdata_o  <= mem[next_word_addr];
      end
   end

   assign axi_arready_o = (state_q == MEM_IDLE);
   assign axi_rvalid_o  = (state_q == MEM_BURST);
   assign axi_rlast_o   = (beats_left_q == '0);

endmodule

`default_nettype wire

/* hw/axis2axi_rd_sys.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axis2axi_cfg.svh"

module axis2axi_rd_sys (
   input  wire                      clk_i,
   input  wire                      reset_i,

   input  wire  [`AXI_ADDR_W-1:0]   config_addr_i,
   input  wire  [`AXI_ADDR_W-1:0]   config_length_i,
   input  wire                      config_valid_i,
   output logic                     config_ready_o,

   output logic [`AXI_DATA_W-1:0]   stream_data_o,
   output logic                     stream_valid_o,
   input  wire                      stream_ready_i,

   input  wire                      load_en_i,
   input  wire  [`MEM_ADDR_W-1:0]   load_addr_i,
   input  wire  [`AXI_DATA_W-1:0]   load_data_i
);

   import axi_pkg::*;

   logic [`AXI_ADDR_W-1:0] axi_araddr;
   logic [`AXI_LEN_W-1:0]  axi_arlen;
   axi_burst_t             axi_arburst;
   logic                   axi_arvalid;
   logic                   axi_arready;
   logic [`AXI_DATA_W-1:0] axi_rdata;
   logic                   axi_rlast;
   logic                   axi_rvalid;
   logic                   axi_rready;

   axis2axi_out u_axis2axi_out (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .config_addr_i   (config_addr_i),
      .config_length_i (config_length_i),
      .config_valid_i  (config_valid_i),
      .config_ready_o  (config_ready_o),
      .axi_araddr_o    (axi_araddr),
      .axi_arlen_o     (axi_arlen),
      // Memory serves 4-byte beats only
      .axi_arsize_o    (),
      .axi_arburst_o   (axi_arburst),
      .axi_arvalid_o   (axi_arvalid),
      .axi_arready_i   (axi_arready),
      .axi_rdata_i     (axi_rdata),
      .axi_rlast_i     (axi_rlast),
      .axi_rvalid_i    (axi_rvalid),
      .axi_rready_o    (axi_rready),
      .stream_data_o   (stream_data_o),
      .stream_valid_o  (stream_valid_o),
      .stream_ready_i  (stream_ready_i)
   );

   axi_rd_mem u_axi_rd_mem (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .load_en_i     (load_en_i),
      .load_addr_i   (load_addr_i),
      .load_data_i   (load_data_i),
      .axi_araddr_i  (axi_araddr),
      .axi_arlen_i   (axi_arlen),
      .axi_arburst_i (axi_arburst),
      .axi_arvalid_i (axi_arvalid),
      .axi_arready_o (axi_arready),
      .axi_rdata_o   (axi_rdata),
      .axi_rlast_o   (axi_rlast),
      .axi_rvalid_o  (axi_rvalid),
      .axi_rready_i  (axi_rready)
   );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f tb.f \
      --top-module tb_axis2axi_rd -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^Simulation passed$"; then
   exit 0
fi

echo "Pass message not found in the output"
exit 1

/* tb.f */
+incdir+common
common/axi_pkg.sv
common/dma_pkg.sv
axis2axi/burst_len_calc.sv
axis2axi/axis2axi_out.sv
hw/axi_rd_mem.sv
hw/axis2axi_rd_sys.sv
bench/axis2axi_out_assert.sv
bench/tb_axis2axi_rd.sv
